// File: boot_load_input.txt
# test: name, stall percent (decimal), expected err_code (0 ok, 1 hdr, 2 seg, 3 size), fill seed
# seg: index, length, flash address (hex); flip: flash address, XOR mask (hex); run: load
test good_three 0 0 5a
seg 0 11 1000
seg 1 9 2040
seg 2 c 1f00a3
run
test skip_middle 0 0 c3
seg 0 14 8000
seg 1 0 9000
seg 2 b 12345
run
test bad_header 0 1 77
seg 0 5 4000
seg 1 6 4100
seg 2 7 4200
flip 438 1
run
test bad_seg1 0 2 19
seg 0 8 6000
seg 1 a 6100
seg 2 6 6200
flip 610a 80
run
test too_big 0 3 e4
seg 0 258 10000
seg 1 1f4 20000
seg 2 a 30000
run
test good_stall 50 0 5a
seg 0 11 1000
seg 1 9 2040
seg 2 c 1f00a3
run

// File: files.f
boot_pkg.sv
crc32_byte.sv
flash_read_ctrl.sv
boot_load_xfer.sv
init_ram.sv
boot_load_top.sv
tb_boot_load.sv

// File: Bender.yml
package:
  name: boot_load

sources:
  - boot_pkg.sv
  - crc32_byte.sv
  - flash_read_ctrl.sv
  - boot_load_xfer.sv
  - init_ram.sv
  - boot_load_top.sv
  - target: simulation
    files:
      - tb_boot_load.sv

// File: tb_boot_load.sv
`timescale 1ns/1ps
`default_nettype none

module tb_boot_load;

	localparam int RAM_AW = 10;
	localparam int WAIT_CYCLES = 20000;
	localparam int CHECK_BYTES = 64;

	logic sys_clk = 1'b0;
	logic glbl_rst_n;
	logic start;
	logic flash_rd_ready;
	logic [7:0] flash_rd_data;
	logic [RAM_AW-1:0] ram_rd_addr;
	wire flash_rd_valid;
	wire [boot_pkg::FLASH_AW-1:0] flash_rd_addr;
	wire done;
	wire error;
	boot_pkg::load_err_e err_code;
	boot_pkg::seg_info_t seg_info;
	wire [7:0] ram_rd_data;

	logic [7:0] flash_mem [int];
	logic [7:0] ram_model [0:CHECK_BYTES-1];
	logic [24:0] flip_addr [$];
	logic [7:0] flip_mask [$];
	logic [boot_pkg::LEN_W-1:0] seg_len [3];
	logic [24:0] seg_addr [3];
	logic [7:0] fill_seed = 8'h00;
	int stall_pct = 0;
	int errors;
	int pass_cnt = 0;
	int fail_cnt = 0;
	logic fire_q = 1'b0;
	logic [24:0] addr_q;

	boot_load_top #(
		.RAM_AW(RAM_AW)
	) boot_load_top_i (
		.sys_clk(sys_clk),
		.glbl_rst_n(glbl_rst_n),
		.start(start),
		.flash_rd_valid(flash_rd_valid),
		.flash_rd_addr(flash_rd_addr),
		.flash_rd_ready(flash_rd_ready),
		.flash_rd_data(flash_rd_data),
		.done(done),
		.error(error),
		.err_code(err_code),
		.seg_info(seg_info),
		.ram_rd_addr(ram_rd_addr),
		.ram_rd_data(ram_rd_data)
	);

	always #50 sys_clk = ~sys_clk;

	//////////////////////////////////////////////////////////////////////
	// Flash model
	//////////////////////////////////////////////////////////////////////

	// Segment data is not stored, it follows the address
	function automatic logic [7:0] fill_byte(input logic [24:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ fill_seed;
	endfunction

	function automatic logic [7:0] flash_byte(input logic [24:0] a);
		return flash_mem.exists(int'(a)) ? flash_mem[int'(a)] : fill_byte(a);
	endfunction

	// Read request as the DUT sees it at the next edge
	always @(negedge sys_clk)
	begin
		fire_q = flash_rd_valid && flash_rd_ready;
		addr_q = flash_rd_addr;
	end

	initial
	begin
		void'($urandom(77248));
		forever
		begin
			@(posedge sys_clk);
			#5;
			if (fire_q)
				flash_rd_data = flash_byte(addr_q);
			flash_rd_ready = ($urandom % 100) >= stall_pct;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Image build
	//////////////////////////////////////////////////////////////////////

	// Standard CRC-32, final value inverted
	function automatic logic [31:0] crc_calc(input logic [24:0] a, input int len);
		logic [31:0] r;
		logic [7:0] b;
		r = 32'hFFFFFFFF;
		for (int i = 0; i < len; i++)
		begin
			b = flash_byte(a + i);
			for (int j = 0; j < 8; j++)
			begin
				if (r[0] ^ b[j])
					r = (r >> 1) ^ 32'hEDB88320;
				else
					r = r >> 1;
			end
		end
		return ~r;
	endfunction

	function automatic logic [31:0] stored_word(input logic [24:0] a);
		return {flash_byte(a + 3), flash_byte(a + 2), flash_byte(a + 1), flash_byte(a)};
	endfunction

	task automatic put_word(input logic [24:0] a, input logic [31:0] w);
		for (int i = 0; i < 4; i++)
			flash_mem[int'(a + i)] = w[8*i +: 8];
	endtask

	task automatic build_image();
		logic [24:0] h;
		h = boot_pkg::HEADER_ADDR;
		flash_mem.delete();
		for (int k = 0; k < 3; k++)
		begin
			put_word(h + 8*k, {8'd0, seg_len[k]});
			put_word(h + 8*k + 4, {7'd0, seg_addr[k]});
			if (seg_len[k] != 0)
				put_word(seg_addr[k] + seg_len[k], crc_calc(seg_addr[k], seg_len[k]));
		end
		put_word(h + 24, crc_calc(h, 24));
		foreach (flip_addr[i])
			flash_mem[int'(flip_addr[i])] = flash_byte(flip_addr[i]) ^ flip_mask[i];
	endtask

	// Data bytes land in RAM up to and including a segment with a bad CRC
	task automatic update_model(input boot_pkg::load_err_e exp);
		int p;
		logic stop;
		p = 0;
		stop = (exp == boot_pkg::ERR_HDR_CRC) || (exp == boot_pkg::ERR_SIZE);
		for (int k = 0; k < 3 && !stop; k++)
		begin
			for (int i = 0; i < seg_len[k]; i++)
			begin
				if (p < CHECK_BYTES)
					ram_model[p] = flash_byte(seg_addr[k] + i);
				p++;
			end
			if (seg_len[k] != 0 && crc_calc(seg_addr[k], seg_len[k]) !=
				stored_word(seg_addr[k] + seg_len[k]))
				stop = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_code(input boot_pkg::load_err_e got, input boot_pkg::load_err_e exp);
		if (got !== exp)
		begin
			$display("** Error: %0t ns err_code = %s, expected %s", $time, got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic check_seg(input boot_pkg::seg_info_t got, input boot_pkg::seg_info_t exp);
		if (got !== exp)
		begin
			$display("** Error: %0t ns seg_info = %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input int a, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %0t ns ram_rd_data[%0d] = %h, expected %h", $time, a, got, exp);
			errors++;
		end
	endtask

	task automatic run_test(input logic [8*32-1:0] name, input boot_pkg::load_err_e exp_code);
		logic seen;
		logic got_done;
		boot_pkg::seg_info_t exp_seg;
		errors = 0;
		build_image();
		exp_seg = '{len2: seg_len[2], len1: seg_len[1], len0: seg_len[0]};
		@(posedge sys_clk);
		#5;
		start = 1'b1;
		@(posedge sys_clk);
		#5;
		start = 1'b0;
		seen = 1'b0;
		got_done = 1'b0;
		for (int cyc = 0; cyc < WAIT_CYCLES && !seen; cyc++)
		begin
			@(negedge sys_clk);
			if (done || error)
			begin
				seen = 1'b1;
				got_done = done;
			end
		end
		if (!seen)
		begin
			$display("test %0s: no done or error pulse within %0d cycles", name, WAIT_CYCLES);
			errors++;
		end
		else
		begin
			if (got_done != (exp_code == boot_pkg::ERR_NONE))
			begin
				$display("test %0s: load ended with the wrong pulse, done %0b error %0b",
					name, done, error);
				errors++;
			end
			check_code(err_code, exp_code);
			if (exp_code == boot_pkg::ERR_NONE)
				check_seg(seg_info, exp_seg);
		end
		update_model(exp_code);
		for (int a = 0; a < CHECK_BYTES; a++)
		begin
			@(posedge sys_clk);
			#5;
			ram_rd_addr = a;
			@(posedge sys_clk);
			@(negedge sys_clk);
			check_byte(a, ram_rd_data, ram_model[a]);
		end
		if (errors == 0)
		begin
			$display("test %0s: ok", name);
			pass_cnt++;
		end
		else
		begin
			$display("test %0s: %0d mismatches", name, errors);
			fail_cnt++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [8*128-1:0] line;
		logic [8*32-1:0] kw;
		logic [8*32-1:0] name;
		int fd;
		int code;
		int idx;
		int n;
		logic [31:0] v1;
		logic [31:0] v2;
		glbl_rst_n = 1'b0;
		start = 1'b0;
		flash_rd_ready = 1'b1;
		flash_rd_data = 8'h00;
		ram_rd_addr = '0;
		name = '0;
		code = 0;
		for (int i = 0; i < CHECK_BYTES; i++)
			ram_model[i] = 8'hxx;
		repeat (16) @(posedge sys_clk);
		#5;
		glbl_rst_n = 1'b1;
		fd = $fopen("boot_load_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open boot_load_input.txt");
			fail_cnt++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = '0;
				kw = '0;
				n = $fgets(line, fd);
				if ($sscanf(line, "%s", kw) == 1)
				begin
					if (kw == "test")
					begin
						n = $sscanf(line, "test %s %d %d %h", name, stall_pct, code, fill_seed);
						flip_addr.delete();
						flip_mask.delete();
					end
					else if (kw == "seg")
					begin
						n = $sscanf(line, "seg %d %h %h", idx, v1, v2);
						seg_len[idx] = v1[boot_pkg::LEN_W-1:0];
						seg_addr[idx] = v2[24:0];
					end
					else if (kw == "flip")
					begin
						n = $sscanf(line, "flip %h %h", v1, v2);
						flip_addr.push_back(v1[24:0]);
						flip_mask.push_back(v2[7:0]);
					end
					else if (kw == "run")
						run_test(name, boot_pkg::load_err_e'(code));
				end
			end
			$fclose(fd);
		end
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: boot_load_top.sv
`timescale 1ns/1ps
`default_nettype none

module boot_load_top #(
	parameter int RAM_AW = 10
) (
	input wire sys_clk,
	input wire glbl_rst_n,
	input wire start,
	output logic flash_rd_valid,
	output logic [boot_pkg::FLASH_AW-1:0] flash_rd_addr,
	input wire flash_rd_ready,
	input wire [7:0] flash_rd_data,
	output logic done,
	output logic error,
	output boot_pkg::load_err_e err_code,
	output boot_pkg::seg_info_t seg_info,
	input wire [RAM_AW-1:0] ram_rd_addr,
	output logic [7:0] ram_rd_data
);

	boot_pkg::flash_req_t req;
	boot_pkg::byte_beat_t beat;
	logic req_valid;
	logic req_ready;
	logic beat_valid;
	logic crc_init;
	logic crc_chk;
	logic crc_ok;
	logic ram_we;
	logic [RAM_AW-1:0] ram_waddr;
	logic [7:0] ram_wdata;

	boot_load_xfer #(
		.RAM_AW(RAM_AW)
	) boot_load_xfer_i (
		.sys_clk(sys_clk),
		.glbl_rst_n(glbl_rst_n),
		.start(start),
		.req_ready(req_ready),
		.beat(beat),
		.beat_valid(beat_valid),
		.crc_chk(crc_chk),
		.crc_ok(crc_ok),
		.req(req),
		.req_valid(req_valid),
		.crc_init(crc_init),
		.ram_we(ram_we),
		.ram_waddr(ram_waddr),
		.ram_wdata(ram_wdata),
		.done(done),
		.error(error),
		.err_code(err_code),
		.seg_info(seg_info)
	);

	flash_read_ctrl flash_read_ctrl_i (
		.sys_clk(sys_clk),
		.glbl_rst_n(glbl_rst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.flash_rd_valid(flash_rd_valid),
		.flash_rd_addr(flash_rd_addr),
		.flash_rd_ready(flash_rd_ready),
		.flash_rd_data(flash_rd_data),
		.beat(beat),
		.beat_valid(beat_valid)
	);

	// Checks every byte stream, header and segments alike
	crc32_byte crc32_byte_i (
		.sys_clk(sys_clk),
		.glbl_rst_n(glbl_rst_n),
		.crc_init(crc_init),
		.beat(beat),
		.beat_valid(beat_valid),
		.crc_chk(crc_chk),
		.crc_ok(crc_ok)
	);

	init_ram #(
		.RAM_AW(RAM_AW)
	) init_ram_i (
		.sys_clk(sys_clk),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata),
		.raddr(ram_rd_addr),
		.rdata(ram_rd_data)
	);

endmodule

`default_nettype wire

// File: init_ram.sv
`timescale 1ns/1ps
`default_nettype none

module init_ram #(
	parameter int RAM_AW = 10
) (
	input wire sys_clk,
	input wire we,
	input wire [RAM_AW-1:0] waddr,
	input wire [7:0] wdata,
	input wire [RAM_AW-1:0] raddr,
	output logic [7:0] rdata
);

	localparam int DEPTH = 1 << RAM_AW;

	logic [7:0] mem [0:DEPTH-1];

	//////////////////////////////////////////////////////////////////////
	// Write from the loader
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	//////////////////////////////////////////////////////////////////////
	// Registered readback
	//////////////////////////////////////////////////////////////////////

	// One cycle of latency
	always_ff @(posedge sys_clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: boot_load_xfer.sv
`timescale 1ns/1ps
`default_nettype none

module boot_load_xfer #(
	parameter int RAM_AW = 10
) (
	input wire sys_clk,
	input wire glbl_rst_n,
	input wire start,
	input wire req_ready,
	input wire boot_pkg::byte_beat_t beat,
	input wire beat_valid,
	input wire crc_chk,
	input wire crc_ok,
	output boot_pkg::flash_req_t req,
	output logic req_valid,
	output logic crc_init,
	output logic ram_we,
	output logic [RAM_AW-1:0] ram_waddr,
	output logic [7:0] ram_wdata,
	output logic done,
	output logic error,
	output boot_pkg::load_err_e err_code,
	output boot_pkg::seg_info_t seg_info
);

	localparam logic [33:0] RAM_SIZE = 34'd1 << RAM_AW;

	boot_pkg::xfer_state_e state;
	boot_pkg::xfer_state_e next_seg;
	logic [223:0] hdr_sr;
	logic launch;
	logic in_seg;
	logic [boot_pkg::LEN_W-1:0] seg_cnt;
	logic [RAM_AW:0] wr_ptr;
	logic [31:0] len_raw [3];
	logic [boot_pkg::FLASH_AW-1:0] seg_addr [3];
	logic [33:0] len_sum;
	logic [boot_pkg::LEN_W-1:0] cur_len;
	logic [boot_pkg::FLASH_AW-1:0] cur_addr;

	//////////////////////////////////////////////////////////////////////
	// Header fields
	//////////////////////////////////////////////////////////////////////

	// Byte 0 ends up in the low bits
	always_ff @(posedge sys_clk)
	begin
		if (state == boot_pkg::HEADER && beat_valid)
			hdr_sr <= {beat.data, hdr_sr[223:8]};
	end

	always_comb
	begin
		for (int k = 0; k < 3; k++)
		begin
			len_raw[k] = hdr_sr[64*k +: 32];
			seg_addr[k] = hdr_sr[64*k+32 +: boot_pkg::FLASH_AW];
		end
	end

	// Full 32-bit lengths, so stray upper bytes also fail the size check
	assign len_sum = {2'b00, len_raw[0]} + {2'b00, len_raw[1]} + {2'b00, len_raw[2]};

	always_comb
	begin
		cur_len = len_raw[0][boot_pkg::LEN_W-1:0];
		cur_addr = seg_addr[0];
		next_seg = boot_pkg::SEG1;
		in_seg = 1'b1;
		case (state)
			boot_pkg::SEG0:
				in_seg = 1'b1;
			boot_pkg::SEG1:
			begin
				cur_len = len_raw[1][boot_pkg::LEN_W-1:0];
				cur_addr = seg_addr[1];
				next_seg = boot_pkg::SEG2;
			end
			boot_pkg::SEG2:
			begin
				cur_len = len_raw[2][boot_pkg::LEN_W-1:0];
				cur_addr = seg_addr[2];
				next_seg = boot_pkg::FINISH;
			end
			default:
				in_seg = 1'b0;
		endcase
	end

	// Data bytes go to RAM, the trailing CRC bytes do not
	assign ram_we = beat_valid && in_seg && !launch && (seg_cnt < cur_len);
	assign ram_waddr = wr_ptr[RAM_AW-1:0];
	assign ram_wdata = beat.data;

	always_ff @(posedge sys_clk)
	begin
		if (state == boot_pkg::IDLE && start)
			req <= '{addr: boot_pkg::HEADER_ADDR, len: boot_pkg::HEADER_LEN};
		else if (in_seg && launch)
			req <= '{addr: cur_addr, len: cur_len + 24'd4};
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state <= boot_pkg::IDLE;
			req_valid <= 1'b0;
			crc_init <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
			err_code <= boot_pkg::ERR_NONE;
			seg_info <= '0;
			launch <= 1'b0;
			seg_cnt <= '0;
			wr_ptr <= '0;
		end
		else
		begin
			crc_init <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
			if (req_valid && req_ready)
				req_valid <= 1'b0;
			if (ram_we)
				wr_ptr <= wr_ptr + 1'b1;
			if (beat_valid && in_seg)
				seg_cnt <= seg_cnt + 1'b1;
			case (state)
				boot_pkg::IDLE:
					if (start)
					begin
						req_valid <= 1'b1;
						crc_init <= 1'b1;
						err_code <= boot_pkg::ERR_NONE;
						seg_info <= '0;
						wr_ptr <= '0;
						state <= boot_pkg::HEADER;
					end
				boot_pkg::HEADER:
					if (crc_chk)
					begin
						if (!crc_ok)
						begin
							error <= 1'b1;
							err_code <= boot_pkg::ERR_HDR_CRC;
							state <= boot_pkg::IDLE;
						end
						else if (len_sum > RAM_SIZE)
						begin
							error <= 1'b1;
							err_code <= boot_pkg::ERR_SIZE;
							state <= boot_pkg::IDLE;
						end
						else
						begin
							launch <= 1'b1;
							state <= boot_pkg::SEG0;
						end
					end
				boot_pkg::SEG0, boot_pkg::SEG1, boot_pkg::SEG2:
					if (launch)
					begin
						// Empty segment is skipped without a flash read
						if (cur_len == 0)
							state <= next_seg;
						else
						begin
							launch <= 1'b0;
							req_valid <= 1'b1;
							crc_init <= 1'b1;
							seg_cnt <= '0;
						end
					end
					else if (crc_chk)
					begin
						if (!crc_ok)
						begin
							error <= 1'b1;
							err_code <= boot_pkg::ERR_SEG_CRC;
							state <= boot_pkg::IDLE;
						end
						else
						begin
							launch <= 1'b1;
							state <= next_seg;
						end
					end
				boot_pkg::FINISH:
				begin
					done <= 1'b1;
					seg_info <= '{len2: len_raw[2][boot_pkg::LEN_W-1:0],
						len1: len_raw[1][boot_pkg::LEN_W-1:0],
						len0: len_raw[0][boot_pkg::LEN_W-1:0]};
					state <= boot_pkg::IDLE;
				end
				default:
					state <= boot_pkg::IDLE;
			endcase
		end
	end

	// Size check keeps the write pointer inside the RAM
	a_waddr_range: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		ram_we |-> !wr_ptr[RAM_AW]);

endmodule

`default_nettype wire

// File: flash_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module flash_read_ctrl (
	input wire sys_clk,
	input wire glbl_rst_n,
	input wire boot_pkg::flash_req_t req,
	input wire req_valid,
	output logic req_ready,
	output logic flash_rd_valid,
	output logic [boot_pkg::FLASH_AW-1:0] flash_rd_addr,
	input wire flash_rd_ready,
	input wire [7:0] flash_rd_data,
	output boot_pkg::byte_beat_t beat,
	output logic beat_valid
);

	logic busy;
	logic [boot_pkg::LEN_W-1:0] remain;
	logic rd_fire;
	logic rd_pend;
	logic rd_last_pend;

	assign req_ready = !busy;
	assign rd_fire = flash_rd_valid && flash_rd_ready;

	//////////////////////////////////////////////////////////////////////
	// Read issue
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			busy <= 1'b0;
			flash_rd_valid <= 1'b0;
			rd_pend <= 1'b0;
			rd_last_pend <= 1'b0;
		end
		else
		begin
			rd_pend <= rd_fire;
			rd_last_pend <= rd_fire && (remain == 1);
			if (req_valid && req_ready)
			begin
				busy <= 1'b1;
				flash_rd_valid <= 1'b1;
			end
			else if (rd_fire && (remain == 1))
				flash_rd_valid <= 1'b0;
			// Free again once the final byte is out
			if (rd_pend && rd_last_pend)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (req_valid && req_ready)
		begin
			flash_rd_addr <= req.addr;
			remain <= req.len;
		end
		else if (rd_fire)
		begin
			flash_rd_addr <= flash_rd_addr + 1'b1;
			remain <= remain - 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Returned bytes
	//////////////////////////////////////////////////////////////////////

	// Flash data is valid the cycle after its read was taken
	assign beat_valid = rd_pend;
	assign beat = '{data: flash_rd_data, last: rd_last_pend};

	// Stalled read keeps its address
	a_addr_hold: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		flash_rd_valid && !flash_rd_ready |=> flash_rd_valid && $stable(flash_rd_addr));

	// Sequencer waits for the previous request to drain
	a_no_req_busy: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		busy |-> !req_valid);

endmodule

`default_nettype wire

// File: crc32_byte.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_byte (
	input wire sys_clk,
	input wire glbl_rst_n,
	input wire crc_init,
	input wire boot_pkg::byte_beat_t beat,
	input wire beat_valid,
	output logic crc_chk,
	output logic crc_ok
);

	localparam logic [31:0] CRC_POLY = 32'hEDB88320;

	logic [31:0] crc_q;
	logic [31:0] crc_next;

	// Reflected update, LSB of the byte first
	function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		c = crc ^ {24'd0, data};
		for (int i = 0; i < 8; i++)
			c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
		return c;
	endfunction

	assign crc_next = crc_step(crc_q, beat.data);

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			crc_q <= '1;
			crc_chk <= 1'b0;
			crc_ok <= 1'b0;
		end
		else
		begin
			crc_chk <= beat_valid && beat.last;
			if (beat_valid && beat.last)
				crc_ok <= (crc_next == boot_pkg::CRC_RESIDUE);
			if (crc_init)
				crc_q <= '1;
			else if (beat_valid)
				crc_q <= crc_next;
		end
	end

endmodule

`default_nettype wire

// File: boot_pkg.sv
`default_nettype none

package boot_pkg;

	//////////////////////////////////////////////////////////////////////
	// Flash geometry and header layout
	//////////////////////////////////////////////////////////////////////

	localparam int FLASH_AW = 25;
	localparam int LEN_W = 24;

	localparam logic [FLASH_AW-1:0] HEADER_ADDR = 25'h420;

	// Three descriptors of length and address, then the header CRC
	localparam logic [LEN_W-1:0] HEADER_LEN = 24'd28;

	// Register value after a good message followed by its own CRC
	localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

	//////////////////////////////////////////////////////////////////////
	// Transfer records
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [FLASH_AW-1:0] addr;
		logic [LEN_W-1:0] len;
	} flash_req_t;

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} byte_beat_t;

	// Segment 0 sits in the low bits
	typedef struct packed {
		logic [LEN_W-1:0] len2;
		logic [LEN_W-1:0] len1;
		logic [LEN_W-1:0] len0;
	} seg_info_t;

	//////////////////////////////////////////////////////////////////////
	// Codes and states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ERR_NONE = 2'd0,
		ERR_HDR_CRC = 2'd1,
		ERR_SEG_CRC = 2'd2,
		ERR_SIZE = 2'd3
	} load_err_e;

	typedef enum logic [2:0] {
		IDLE = 3'd0,
		HEADER = 3'd1,
		SEG0 = 3'd2,
		SEG1 = 3'd3,
		SEG2 = 3'd4,
		FINISH = 3'd5
	} xfer_state_e;

endpackage

`default_nettype wire
